// File: hw/bram_cfg.svh
/*
 * Backup RAM and SD image sizing
 * Console byte address width, sectors per image,
 * word index inside a sector and sector number width
 */

`ifndef BRAM_CFG_SVH
`define BRAM_CFG_SVH

// 8 KiB of backup RAM, byte addressed
`define BRAM_ADDR_W 13

// One image is 16 sectors of 512 bytes
`define BRAM_SECTORS 16

// 256 sixteen-bit words per sector
`define SD_WADDR_W 8

// Sector number as the SD host sees it
`define SD_LBA_W 32

`endif

// File: hw/sd_blk_pkg.sv
/*
 * SD block transfer types
 * Sector request bundle and host buffer stream bundle
 */

`include "bram_cfg.svh"

package sd_blk_pkg;

	// Sector request, driven toward the SD host
	typedef struct packed {
		logic [`SD_LBA_W-1:0] lba;
		logic                 rd;
		logic                 wr;
	} sd_req_t;

	////////////////////////////////////////
	// Buffer side, driven by the SD host
	////////////////////////////////////////

	// ack stays high for a whole sector
	typedef struct packed {
		logic                   ack;
		logic [`SD_WADDR_W-1:0] addr;
		logic [15:0]            data;
		logic                   wr;
	} sd_buf_t;

endpackage

// File: hw/bram_ctl_pkg.sv
/*
 * Backup RAM control types
 * Operation and sequencer state enums,
 * console port bundle and control bundle
 */

`include "bram_cfg.svh"

package bram_ctl_pkg;

	typedef enum logic {
		OP_LOAD,
		OP_SAVE
	} sync_op_e;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_REQ,
		ST_XFER
	} seq_state_e;

	// Console side byte access
	typedef struct packed {
		logic [`BRAM_ADDR_W-1:0] addr;
		logic [7:0]              wdata;
		logic                    we;
	} cpu_port_t;

	// Menu buttons, download and mount status
	typedef struct packed {
		logic load;
		logic save;
		logic autosave_en;
		logic osd_open;
		logic save_download;
		logic img_mounted;
		logic img_readonly;
	} bk_ctl_t;

endpackage

// File: hw/bram_dpram.sv
/*
 * Backup RAM storage
 * 8-bit console port and 16-bit SD buffer port, registered reads
 */

`timescale 1ns/1ps
`include "bram_cfg.svh"

module bram_dpram import sd_blk_pkg::*, bram_ctl_pkg::*; (
	input  logic        clk_sys,
	input  cpu_port_t   cpu,
	input  logic [3:0]  sd_lba_lo,
	input  sd_buf_t     sd_buf,
	output logic [7:0]  cpu_rdata,
	output logic [15:0] sd_rdata
);

	localparam int WADDR_W = `BRAM_ADDR_W - 1;
	localparam int WORDS   = 1 << WADDR_W;

	// Even console byte in the low half, odd byte in the high half
	logic [15:0] mem [WORDS];
	logic [15:0] cpu_word_q;
	logic        cpu_hi_q;

	wire [WADDR_W-1:0] cpu_widx = cpu.addr[`BRAM_ADDR_W-1:1];
	wire [WADDR_W-1:0] sd_widx  = {sd_lba_lo, sd_buf.addr};
	wire               sd_we    = sd_buf.ack & sd_buf.wr;

	always_ff @(posedge clk_sys) begin
		if (cpu.we) begin
			if (cpu.addr[0])
				mem[cpu_widx][15:8] <= cpu.wdata;
			else
				mem[cpu_widx][7:0] <= cpu.wdata;
		end
		if (sd_we)
			mem[sd_widx] <= sd_buf.data;
		cpu_word_q <= mem[cpu_widx];
		cpu_hi_q   <= cpu.addr[0];
		sd_rdata   <= mem[sd_widx];
	end

	// Byte lane picked with the registered address bit
	assign cpu_rdata = cpu_hi_q ? cpu_word_q[15:8] : cpu_word_q[7:0];

endmodule

// File: hw/bram_change_tracker.sv
/*
 * Image enable, unsaved-change flag and trigger edge detection
 * Issues one load or save request per accepted trigger
 */

`timescale 1ns/1ps

module bram_change_tracker import bram_ctl_pkg::*; (
	input  logic     clk_sys,
	input  logic     rst_n,
	input  bk_ctl_t  ctl,
	input  logic     cpu_we,
	input  logic     busy,
	output logic     op_req,
	output sync_op_e op,
	output logic     bk_ena,
	output logic     sav_pending
);

	logic load_q;
	logic save_q;
	logic auto_q;
	logic dl_q;
	logic we_q;

	wire auto_now  = ctl.autosave_en & ctl.osd_open;
	wire load_edge = ctl.load & ~load_q;
	wire save_edge = ctl.save & ~save_q;
	wire auto_edge = auto_now & ~auto_q & sav_pending;
	wire dl_start  = ctl.save_download & ~dl_q;
	wire dl_end    = ~ctl.save_download & dl_q;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			load_q      <= 1'b0;
			save_q      <= 1'b0;
			auto_q      <= 1'b0;
			dl_q        <= 1'b0;
			we_q        <= 1'b0;
			op_req      <= 1'b0;
			op          <= OP_LOAD;
			bk_ena      <= 1'b0;
			sav_pending <= 1'b0;
		end else begin
			load_q <= ctl.load;
			save_q <= ctl.save;
			auto_q <= auto_now;
			dl_q   <= ctl.save_download;
			we_q   <= cpu_we;

			// A fresh download drops the old image until it is remounted
			if (dl_start)
				bk_ena <= 1'b0;
			if (ctl.save_download && ctl.img_mounted && !ctl.img_readonly)
				bk_ena <= 1'b1;

			if (cpu_we && !we_q)
				sav_pending <= 1'b1;
			else if (busy)
				sav_pending <= 1'b0;

			////////////////////////////////////////
			// Requests, load wins over save
			////////////////////////////////////////
			op_req <= 1'b0;
			if (bk_ena && !busy) begin
				if (load_edge || dl_end) begin
					op_req <= 1'b1;
					op     <= OP_LOAD;
				end else if (save_edge || auto_edge) begin
					op_req <= 1'b1;
					op     <= OP_SAVE;
				end
			end
		end
	end

endmodule

// File: hw/bram_sync_seq.sv
/*
 * Sector sequencer
 * Walks all image sectors, one rd or wr request each,
 * and follows the host ack for every transfer
 */

`timescale 1ns/1ps
`include "bram_cfg.svh"

module bram_sync_seq import sd_blk_pkg::*, bram_ctl_pkg::*; (
	input  logic     clk_sys,
	input  logic     rst_n,
	input  logic     op_req,
	input  sync_op_e op,
	input  logic     ack,
	output sd_req_t  sd_req,
	output logic     busy,
	output logic     reload
);

	localparam int SECT_W = $clog2(`BRAM_SECTORS);

	seq_state_e        state;
	logic [SECT_W-1:0] sect;
	logic              rd_q;
	logic              wr_q;
	logic              ack_q;
	logic              loading;

	wire ack_rise  = ack & ~ack_q;
	wire ack_fall  = ~ack & ack_q;
	wire last_sect = (sect == SECT_W'(`BRAM_SECTORS - 1));
	wire active    = (state != ST_IDLE);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state   <= ST_IDLE;
			sect    <= '0;
			rd_q    <= 1'b0;
			wr_q    <= 1'b0;
			ack_q   <= 1'b0;
			loading <= 1'b0;
		end else begin
			ack_q <= ack;
			case (state)
				ST_IDLE: begin
					if (op_req) begin
						loading <= (op == OP_LOAD);
						sect    <= '0;
						rd_q    <= (op == OP_LOAD);
						wr_q    <= (op == OP_SAVE);
						state   <= ST_REQ;
					end
				end

				// Hold the request until the host takes it
				ST_REQ: begin
					if (ack_rise) begin
						rd_q  <= 1'b0;
						wr_q  <= 1'b0;
						state <= ST_XFER;
					end
				end

				// Sector done on falling ack
				ST_XFER: begin
					if (ack_fall) begin
						sect <= sect + 1'b1;
						if (last_sect) begin
							state <= ST_IDLE;
						end else begin
							rd_q  <= loading;
							wr_q  <= ~loading;
							state <= ST_REQ;
						end
					end
				end

				default: state <= ST_IDLE;
			endcase
		end
	end

	// Sector number only moves after ack has fallen
	assign sd_req = '{lba: `SD_LBA_W'(sect), rd: rd_q, wr: wr_q};

	// The accepted request already counts as busy
	assign busy   = active | op_req;
	assign reload = active ? loading : (op_req & (op == OP_LOAD));

endmodule

// File: hw/bram_save_top.sv
/*
 * Backup RAM save and load subsystem
 * Change tracker, sector sequencer and dual-port RAM
 */

`timescale 1ns/1ps

module bram_save_top import sd_blk_pkg::*, bram_ctl_pkg::*; (
	input  logic        clk_sys,
	input  logic        rst_n,
	input  cpu_port_t   cpu,
	input  bk_ctl_t     ctl,
	input  sd_buf_t     sd_buf,
	output logic [7:0]  cpu_rdata,
	output sd_req_t     sd_req,
	output logic [15:0] sd_buff_din,
	output logic        bk_ena,
	output logic        sav_pending,
	output logic        busy,
	output logic        reload
);

	logic     op_req;
	sync_op_e op;

	bram_change_tracker tracker_inst (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.ctl         (ctl),
		.cpu_we      (cpu.we),
		.busy        (busy),
		.op_req      (op_req),
		.op          (op),
		.bk_ena      (bk_ena),
		.sav_pending (sav_pending)
	);

	bram_sync_seq seq_inst (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.op_req  (op_req),
		.op      (op),
		.ack     (sd_buf.ack),
		.sd_req  (sd_req),
		.busy    (busy),
		.reload  (reload)
	);

	// Low sector bits select the 512-byte slice of the RAM
	bram_dpram dpram_inst (
		.clk_sys   (clk_sys),
		.cpu       (cpu),
		.sd_lba_lo (sd_req.lba[3:0]),
		.sd_buf    (sd_buf),
		.cpu_rdata (cpu_rdata),
		.sd_rdata  (sd_buff_din)
	);

endmodule

// File: tb/sd_image_model.sv
/*
 * Behavioral SD host
 * Holds a 16-sector image and answers sector read and write requests
 * with a random acknowledge delay
 */

`timescale 1ns/1ps
`include "bram_cfg.svh"

module sd_image_model import sd_blk_pkg::*; #(
	parameter logic [31:0] SEED = 32'h1e68b970
) (
	input  logic        clk_sys,
	input  sd_req_t     sd_req,
	input  logic [15:0] sd_buff_din,
	output sd_buf_t     sd_buf
);

	localparam int WORDS = `BRAM_SECTORS << `SD_WADDR_W;

	logic [15:0] image [WORDS];
	integer      seed;

	initial begin : host
		logic [31:0] rnd;
		logic [3:0]  lba;
		logic        is_rd;
		int          delay;

		seed   = SEED;
		sd_buf = '0;
		// Odd multiplier keeps every word distinct
		for (int w = 0; w < WORDS; w++)
			image[w] = 16'(w * 40503) ^ 16'h5a3c;

		forever begin
			@(negedge clk_sys);
			if (sd_req.rd || sd_req.wr) begin
				is_rd = sd_req.rd;
				lba   = sd_req.lba[3:0];
				rnd   = $random(seed);
				delay = int'(rnd[2:0]);
				repeat (delay) @(negedge clk_sys);
				sd_buf.ack = 1'b1;
				if (is_rd) begin
					for (int i = 0; i < 256; i++) begin
						sd_buf.addr = i[7:0];
						sd_buf.data = image[{lba, i[7:0]}];
						sd_buf.wr   = 1'b1;
						@(negedge clk_sys);
					end
					sd_buf.wr = 1'b0;
				end else begin
					// Word data arrives one clock after its index
					for (int i = 0; i <= 256; i++) begin
						if (i > 0)
							image[{lba, 8'(i - 1)}] = sd_buff_din;
						if (i < 256) begin
							sd_buf.addr = i[7:0];
							@(negedge clk_sys);
						end
					end
				end
				sd_buf.ack = 1'b0;
			end
		end
	end

endmodule

// File: tb/tb_bram_save.sv
/*
 * Backup RAM subsystem testbench
 * Clock, reset, random console and control stimulus,
 * byte model of the RAM and checks against the SD image
 */

`timescale 1ns/1ps
`include "bram_cfg.svh"

module tb_bram_save import sd_blk_pkg::*, bram_ctl_pkg::*; ();

	localparam int BYTES      = 1 << `BRAM_ADDR_W;
	localparam int START_WAIT = 20;
	localparam int XFER_WAIT  = 20000;
	localparam int QUIET_WAIT = 60;

	logic        clk_sys;
	logic        rst_n;
	cpu_port_t   cpu;
	bk_ctl_t     ctl;
	sd_buf_t     sd_buf;
	logic [7:0]  cpu_rdata;
	sd_req_t     sd_req;
	logic [15:0] sd_buff_din;
	logic        bk_ena;
	logic        sav_pending;
	logic        busy;
	logic        reload;

	logic [7:0]  ram_model [BYTES];
	integer      seed;
	integer      errors;

	bram_save_top bram_save_top_inst (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.cpu         (cpu),
		.ctl         (ctl),
		.sd_buf      (sd_buf),
		.cpu_rdata   (cpu_rdata),
		.sd_req      (sd_req),
		.sd_buff_din (sd_buff_din),
		.bk_ena      (bk_ena),
		.sav_pending (sav_pending),
		.busy        (busy),
		.reload      (reload)
	);

	sd_image_model sd_inst (
		.clk_sys     (clk_sys),
		.sd_req      (sd_req),
		.sd_buff_din (sd_buff_din),
		.sd_buf      (sd_buf)
	);

	initial clk_sys = 1'b0;
	always #20 clk_sys = ~clk_sys;

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	task automatic check_eq(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (expected === actual) else begin
			errors++;
			$display("Error %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	// Even byte in the low half of the image word
	function automatic logic [7:0] image_byte(input int b);
		logic [15:0] word;
		word = sd_inst.image[b >> 1];
		return b[0] ? word[15:8] : word[7:0];
	endfunction

	task automatic pulse_ctl(input bk_ctl_t mask);
		ctl = ctl | mask;
		@(negedge clk_sys);
		ctl = ctl & ~mask;
	endtask

	task automatic download(input string name, input logic exp_ena);
		ctl.save_download = 1'b1;
		repeat (4) @(negedge clk_sys);
		check_eq({name, " bk_ena"}, 16'(exp_ena), 16'(bk_ena));
		ctl.save_download = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic expect_no_request(input string name);
		int seen;
		seen = 0;
		for (int n = 0; n < QUIET_WAIT; n++) begin
			if (sd_req.rd || sd_req.wr || busy)
				seen++;
			@(negedge clk_sys);
		end
		assert (seen == 0) else begin
			errors++;
			$display("%s: an SD transfer started although none was expected", name);
		end
	endtask

	task automatic run_transfer(input string name, input logic exp_reload);
		int   n;
		int   bad;
		int   sectors;
		logic req_q;
		n = 0;
		bad = 0;
		sectors = 0;
		req_q = 1'b0;
		while (busy !== 1'b1 && n < START_WAIT) begin
			@(negedge clk_sys);
			n++;
		end
		assert (busy === 1'b1) else begin
			errors++;
			$display("%s: busy did not rise after the trigger", name);
		end
		n = 0;
		while (busy === 1'b1 && n < XFER_WAIT) begin
			if (reload !== exp_reload)
				bad++;
			// Each new request names the next sector
			if ((sd_req.rd || sd_req.wr) && !req_q) begin
				check_eq($sformatf("%s sector %0d lba", name, sectors),
					32'(sectors), sd_req.lba);
				// rd for a load and wr for a save
				check_eq($sformatf("%s sector %0d request", name, sectors),
					32'({exp_reload, ~exp_reload}), 32'({sd_req.rd, sd_req.wr}));
				sectors++;
			end
			req_q = sd_req.rd | sd_req.wr;
			@(negedge clk_sys);
			n++;
		end
		assert (busy === 1'b0) else begin
			errors++;
			$display("%s: the transfer did not finish in time", name);
		end
		check_eq({name, " reload mismatches"}, 16'd0, 16'(bad));
		check_eq({name, " sector count"}, `BRAM_SECTORS, 32'(sectors));
	endtask

	task automatic check_image(input string name);
		for (int b = 0; b < BYTES; b++)
			check_eq($sformatf("%s byte %0h", name, b), ram_model[b], image_byte(b));
	endtask

	// After a load the console side must see the image
	task automatic read_back_image(input string name);
		for (int b = 0; b < BYTES; b++) begin
			ram_model[b] = image_byte(b);
			cpu.addr = `BRAM_ADDR_W'(b);
			@(negedge clk_sys);
			check_eq($sformatf("%s byte %0h", name, b), ram_model[b], cpu_rdata);
		end
	endtask

	task automatic randomize_image();
		logic [31:0] rnd;
		for (int w = 0; w < BYTES / 2; w++) begin
			rnd = $random(seed);
			sd_inst.image[w] = rnd[15:0];
		end
	endtask

	task automatic write_random_byte();
		logic [31:0] rnd;
		rnd = $random(seed);
		cpu.addr  = rnd[`BRAM_ADDR_W-1:0];
		cpu.wdata = rnd[20:13];
		cpu.we    = 1'b1;
		ram_model[rnd[`BRAM_ADDR_W-1:0]] = rnd[20:13];
		@(negedge clk_sys);
		cpu.we = 1'b0;
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial begin : main
		bk_ctl_t     save_mask;
		bk_ctl_t     load_mask;
		logic [31:0] rnd;

		seed   = 32'h1e68b970;
		errors = 0;
		rst_n  = 1'b0;
		cpu    = '0;
		ctl    = '0;
		save_mask = '0;
		save_mask.save = 1'b1;
		load_mask = '0;
		load_mask.load = 1'b1;
		repeat (3) @(negedge clk_sys);
		rst_n = 1'b1;
		@(negedge clk_sys);
		check_eq("reset outputs", 16'h0,
			{10'h0, sd_req.rd, sd_req.wr, busy, reload, bk_ena, sav_pending});

		// Enable gating, then the first load at the end of a download
		pulse_ctl(save_mask);
		expect_no_request("save without image");
		ctl.img_mounted  = 1'b1;
		ctl.img_readonly = 1'b1;
		download("read-only download", 1'b0);
		pulse_ctl(save_mask);
		expect_no_request("save with read-only image");
		ctl.img_readonly = 1'b0;
		download("writable download", 1'b1);
		run_transfer("initial load", 1'b1);
		read_back_image("initial load");
		check_eq("pending after load", 16'h0, 16'(sav_pending));

		// Console writes and read back
		for (int i = 0; i < 48; i++)
			write_random_byte();
		check_eq("pending after writes", 16'h1, 16'(sav_pending));
		for (int i = 0; i < 96; i++) begin
			rnd = $random(seed);
			cpu.addr = rnd[`BRAM_ADDR_W-1:0];
			@(negedge clk_sys);
			check_eq("console read", ram_model[rnd[`BRAM_ADDR_W-1:0]], cpu_rdata);
		end

		// Manual save
		pulse_ctl(save_mask);
		run_transfer("save", 1'b0);
		check_eq("pending after save", 16'h0, 16'(sav_pending));
		check_image("save");

		// Manual load of a fresh image
		randomize_image();
		pulse_ctl(load_mask);
		run_transfer("load", 1'b1);
		read_back_image("load");

		// Autosave on menu open, only with a change pending
		write_random_byte();
		ctl.autosave_en = 1'b1;
		ctl.osd_open    = 1'b1;
		@(negedge clk_sys);
		run_transfer("autosave", 1'b0);
		check_image("autosave");
		ctl.osd_open = 1'b0;
		@(negedge clk_sys);
		ctl.osd_open = 1'b1;
		expect_no_request("menu open with nothing pending");
		ctl.osd_open    = 1'b0;
		ctl.autosave_en = 1'b0;

		// Load at the end of a save-file download
		randomize_image();
		download("second download", 1'b1);
		run_transfer("download load", 1'b1);
		read_back_image("download load");

		$display("Run complete with %0d errors", errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+hw
hw/sd_blk_pkg.sv
hw/bram_ctl_pkg.sv
hw/bram_dpram.sv
hw/bram_change_tracker.sv
hw/bram_sync_seq.sv
hw/bram_save_top.sv
tb/sd_image_model.sv
tb/tb_bram_save.sv

// File: Makefile
# Verilator build and run for the backup RAM subsystem

VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -Wno-fatal
TOP       := tb_bram_save
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard hw/*.sv hw/*.svh tb/*.sv)
PASS_MSG  := all tests passed

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
